//--- verilog/stream_pkg.sv
`default_nettype none

package stream_pkg;

   localparam int DTYPE_WIDTH = 4;

   // Tags that travel with every stream beat
   typedef enum logic [DTYPE_WIDTH-1:0] {
      DTYPE_NONE         = 4'h0,
      DTYPE_FRAME_START  = 4'h1,
      DTYPE_FRAME_END    = 4'h2,
      DTYPE_HEADER_START = 4'h3,
      DTYPE_HEADER       = 4'h4,
      DTYPE_LINE_START   = 4'h5,
      DTYPE_LINE_END     = 4'h6,
      DTYPE_PIXEL        = 4'h8
   } dtype_e;

   // Any tag with this bit set carries pixel data
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_PIXEL_MASK = 4'h8;

   // Header field order on the stream
   localparam int unsigned HDR_NUM_COLS    = 0;
   localparam int unsigned HDR_NUM_ROWS    = 1;
   localparam int unsigned HDR_IMAGE_TYPE  = 2;
   localparam int unsigned HDR_FRAME_COUNT = 3;

   localparam int unsigned HDR_FIELDS = 4;

endpackage

`default_nettype wire

//--- verilog/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

   typedef enum logic [15:0] {
      IMAGE_RAW = 16'd0,
      IMAGE_RGB = 16'd1
   } image_type_e;

   localparam logic [7:0] ADDR_CTRL       = 8'h00;
   localparam logic [7:0] ADDR_IMAGE_TYPE = 8'h04;
   localparam logic [7:0] ADDR_NUM_COLS   = 8'h08;
   localparam logic [7:0] ADDR_NUM_ROWS   = 8'h0C;
   localparam logic [7:0] ADDR_STATUS     = 8'h10; // Busy in bit 0, frame count in 31:16

   localparam int unsigned CTRL_ENABLE_BIT = 0;
   localparam int unsigned CTRL_START_BIT  = 1; // Reads back as 0

endpackage

`default_nettype wire

//--- verilog/apb_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_cfg_regs
   import cfg_pkg::*;
(
   input  wire              clk,
   input  wire              resetb,

   input  wire              psel,
   input  wire              penable,
   input  wire              pwrite,
   input  wire [7:0]        paddr,
   input  wire [31:0]       pwdata,
   output logic [31:0]      prdata,
   output logic             pready,
   output logic             pslverr,

   output logic             enable,
   output logic             start,
   output image_type_e      image_type,
   output logic [15:0]      num_cols,
   output logic [15:0]      num_rows,
   input  wire              busy,
   input  wire [15:0]       frame_count
);

   logic access;
   logic wr_access;
   logic addr_mapped;

   assign access    = psel && penable;
   assign wr_access = access && pwrite;
   assign pready    = 1'b1; // No wait states

   always_comb begin
      case (paddr)
         ADDR_CTRL,
         ADDR_IMAGE_TYPE,
         ADDR_NUM_COLS,
         ADDR_NUM_ROWS,
         ADDR_STATUS: addr_mapped = 1'b1;
         default:     addr_mapped = 1'b0;
      endcase
   end

   // STATUS is read only, so writing it is an error as well
   assign pslverr = access && (!addr_mapped || (pwrite && paddr == ADDR_STATUS));

   always_comb begin
      prdata = '0;
      case (paddr)
         ADDR_CTRL:       prdata[CTRL_ENABLE_BIT] = enable;
         ADDR_IMAGE_TYPE: prdata[15:0] = image_type;
         ADDR_NUM_COLS:   prdata[15:0] = num_cols;
         ADDR_NUM_ROWS:   prdata[15:0] = num_rows;
         ADDR_STATUS:     prdata = {frame_count, 15'd0, busy};
         default:         prdata = '0;
      endcase
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         enable     <= 1'b0;
         start      <= 1'b0;
         image_type <= IMAGE_RAW;
         num_cols   <= '0;
         num_rows   <= '0;
      end else begin
         // Start is a pulse in the cycle after the CTRL write
         start <= wr_access && (paddr == ADDR_CTRL) && pwdata[CTRL_START_BIT];
         if (wr_access) begin
            case (paddr)
               ADDR_CTRL:       enable <= pwdata[CTRL_ENABLE_BIT];
               ADDR_IMAGE_TYPE: image_type <= image_type_e'(pwdata[15:0]);
               ADDR_NUM_COLS:   num_cols <= pwdata[15:0];
               ADDR_NUM_ROWS:   num_rows <= pwdata[15:0];
               default:         ;
            endcase
         end
      end
   end

   // An APB access needs a setup cycle first, so two starts can never touch
   a_start_single: assert property (@(posedge clk) disable iff (!resetb)
      start |=> !start);

endmodule

`default_nettype wire

//--- verilog/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer
   import stream_pkg::*;
   import cfg_pkg::*;
#(
   parameter int PIXEL_WIDTH = 8
) (
   input  wire                    clk,
   input  wire                    resetb,

   input  wire                    enable,
   input  wire                    start,
   input  wire image_type_e       image_type,
   input  wire [15:0]             num_cols,
   input  wire [15:0]             num_rows,
   output logic                   busy,
   output logic [15:0]            frame_count,

   output logic                   dvi,
   output dtype_e                 dtypei,
   output logic [15:0]            meta_datai,
   output logic [PIXEL_WIDTH-1:0] r,
   output logic [PIXEL_WIDTH-1:0] g,
   output logic [PIXEL_WIDTH-1:0] b
);

   localparam int HDR_IDX_W = $clog2(HDR_FIELDS);

   // The state names the beat currently on the output
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FRAME_START,
      ST_HEADER_START,
      ST_HEADER,
      ST_LINE_START,
      ST_PIXELS,
      ST_LINE_END,
      ST_FRAME_END
   } state_e;

   state_e                 state;
   state_e                 nxt_state;
   logic [15:0]            col;
   logic [15:0]            nxt_col;
   logic [15:0]            row;
   logic [15:0]            nxt_row;
   logic [HDR_IDX_W-1:0]   hdr;
   logic [HDR_IDX_W-1:0]   nxt_hdr;
   logic [15:0]            cols_q;
   logic [15:0]            rows_q;
   image_type_e            type_q;

   logic                   nxt_dv;
   dtype_e                 nxt_dtype;
   logic [15:0]            nxt_meta;
   logic [PIXEL_WIDTH-1:0] nxt_r;
   logic [PIXEL_WIDTH-1:0] nxt_g;
   logic [PIXEL_WIDTH-1:0] nxt_b;
   logic [15:0]            pat_sum;
   logic [15:0]            pat_xor;

   assign busy = (state != ST_IDLE);

   always_comb begin
      nxt_state = state;
      nxt_col   = col;
      nxt_row   = row;
      nxt_hdr   = hdr;
      case (state)
         ST_IDLE: begin
            if (start && enable) begin
               nxt_state = ST_FRAME_START;
            end
         end
         ST_FRAME_START:  nxt_state = ST_HEADER_START;
         ST_HEADER_START: begin
            nxt_state = ST_HEADER;
            nxt_hdr   = '0;
         end
         ST_HEADER: begin
            if (hdr == HDR_IDX_W'(HDR_FIELDS - 1)) begin
               nxt_state = ST_LINE_START;
               nxt_row   = '0;
            end else begin
               nxt_hdr = hdr + HDR_IDX_W'(1);
            end
         end
         ST_LINE_START: begin
            nxt_state = ST_PIXELS;
            nxt_col   = '0;
         end
         ST_PIXELS: begin
            if (col == cols_q - 16'd1) begin
               nxt_state = ST_LINE_END;
            end else begin
               nxt_col = col + 16'd1;
            end
         end
         ST_LINE_END: begin
            if (row == rows_q - 16'd1) begin
               nxt_state = ST_FRAME_END;
            end else begin
               nxt_state = ST_LINE_START;
               nxt_row   = row + 16'd1;
            end
         end
         ST_FRAME_END:    nxt_state = ST_IDLE;
         default:         nxt_state = ST_IDLE;
      endcase
   end

   // Beat contents are built from the next state so they register with it
   always_comb begin
      nxt_dv    = (nxt_state != ST_IDLE);
      nxt_dtype = DTYPE_NONE;
      nxt_meta  = '0;
      nxt_r     = '0;
      nxt_g     = '0;
      nxt_b     = '0;
      pat_sum   = nxt_col + nxt_row;
      pat_xor   = nxt_col ^ nxt_row;
      case (nxt_state)
         ST_FRAME_START:  nxt_dtype = DTYPE_FRAME_START;
         ST_HEADER_START: nxt_dtype = DTYPE_HEADER_START;
         ST_HEADER: begin
            nxt_dtype = DTYPE_HEADER;
            case (nxt_hdr)
               HDR_IDX_W'(HDR_NUM_COLS):    nxt_meta = cols_q;
               HDR_IDX_W'(HDR_NUM_ROWS):    nxt_meta = rows_q;
               HDR_IDX_W'(HDR_IMAGE_TYPE):  nxt_meta = '0; // Filled in by the packer
               HDR_IDX_W'(HDR_FRAME_COUNT): nxt_meta = frame_count;
               default:                     nxt_meta = '0;
            endcase
         end
         ST_LINE_START:   nxt_dtype = DTYPE_LINE_START;
         ST_PIXELS: begin
            nxt_dtype = DTYPE_PIXEL;
            if (type_q == IMAGE_RGB) begin
               nxt_r = nxt_col[PIXEL_WIDTH-1:0];
               nxt_g = nxt_row[PIXEL_WIDTH-1:0];
               nxt_b = pat_xor[PIXEL_WIDTH-1:0];
            end else begin
               nxt_meta = 16'(pat_sum[PIXEL_WIDTH-1:0]);
            end
         end
         ST_LINE_END:     nxt_dtype = DTYPE_LINE_END;
         ST_FRAME_END:    nxt_dtype = DTYPE_FRAME_END;
         default:         nxt_dtype = DTYPE_NONE;
      endcase
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         state       <= ST_IDLE;
         col         <= '0;
         row         <= '0;
         hdr         <= '0;
         cols_q      <= '0;
         rows_q      <= '0;
         type_q      <= IMAGE_RAW;
         frame_count <= '0;
         dvi         <= 1'b0;
         dtypei      <= DTYPE_NONE;
      end else begin
         state  <= nxt_state;
         col    <= nxt_col;
         row    <= nxt_row;
         hdr    <= nxt_hdr;
         dvi    <= nxt_dv;
         dtypei <= nxt_dtype;
         if (state == ST_IDLE && start && enable) begin // Frame geometry is frozen here
            cols_q <= num_cols;
            rows_q <= num_rows;
            type_q <= image_type;
         end
         if (state == ST_FRAME_END) begin
            frame_count <= frame_count + 16'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      meta_datai <= nxt_meta;
      r          <= nxt_r;
      g          <= nxt_g;
      b          <= nxt_b;
   end

   // The frame goes out back to back with no gaps
   a_dvi_in_frame: assert property (@(posedge clk) disable iff (!resetb)
      (state != ST_IDLE && state != ST_FRAME_END) |=> dvi);

endmodule

`default_nettype wire

//--- verilog/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_packer
   import stream_pkg::*;
   import cfg_pkg::*;
#(
   parameter int PIXEL_WIDTH     = 8,
   parameter int RAW_PIXEL_SHIFT = 0
) (
   input  wire                    clk,
   input  wire                    resetb,
   input  wire image_type_e       image_type,

   input  wire                    dvi,
   input  wire dtype_e            dtypei,
   input  wire [15:0]             meta_datai,
   input  wire [PIXEL_WIDTH-1:0]  r,
   input  wire [PIXEL_WIDTH-1:0]  g,
   input  wire [PIXEL_WIDTH-1:0]  b,

   output logic                   dvo,
   output dtype_e                 dtypeo,
   output logic [31:0]            datao
);

   localparam int OBUF_WIDTH = 32 + 3 * PIXEL_WIDTH;
   localparam int POS_WIDTH  = $clog2(OBUF_WIDTH);
   localparam int SLOT_WIDTH = $clog2(HDR_FIELDS);

   logic [OBUF_WIDTH-1:0]  obuf;
   logic [OBUF_WIDTH-1:0]  next_obuf;
   logic [OBUF_WIDTH-1:0]  shifted;
   logic [POS_WIDTH-1:0]   opos;
   logic [POS_WIDTH-1:0]   next_opos;
   logic [POS_WIDTH-1:0]   rem_opos;
   logic [SLOT_WIDTH-1:0]  hdr_slot;
   logic [15:0]            raw_shifted;
   logic [PIXEL_WIDTH-1:0] raw_data;
   logic [15:0]            meta_field;
   logic                   is_raw;
   logic                   pixel_beat;
   logic                   word_ready;

   assign is_raw      = (image_type == IMAGE_RAW);
   assign pixel_beat  = dvi && |(dtypei & DTYPE_PIXEL_MASK);
   assign raw_shifted = meta_datai >> RAW_PIXEL_SHIFT;
   assign raw_data    = raw_shifted[PIXEL_WIDTH-1:0];

   // New bits enter at the bottom, so the oldest bits sit highest
   always_comb begin
      if (is_raw) begin
         next_obuf = {obuf[OBUF_WIDTH-PIXEL_WIDTH-1:0], raw_data};
         next_opos = opos + POS_WIDTH'(PIXEL_WIDTH);
      end else begin
         next_obuf = {obuf[OBUF_WIDTH-3*PIXEL_WIDTH-1:0], r, g, b};
         next_opos = opos + POS_WIDTH'(3 * PIXEL_WIDTH);
      end
   end

   assign word_ready = (next_opos >= POS_WIDTH'(32));
   assign rem_opos   = next_opos - POS_WIDTH'(32); // Bits left over once a word leaves
   assign shifted    = next_obuf >> rem_opos;

   assign meta_field = (hdr_slot == SLOT_WIDTH'(HDR_IMAGE_TYPE)) ? image_type : meta_datai;

   always_ff @(posedge clk) begin
      if (pixel_beat) begin
         obuf <= next_obuf;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo      <= 1'b0;
         dtypeo   <= DTYPE_NONE;
         datao    <= '0;
         opos     <= '0;
         hdr_slot <= '0;
      end else begin
         dtypeo <= dtypei;
         if (pixel_beat) begin
            if (word_ready) begin
               dvo   <= 1'b1;
               datao <= shifted[31:0];
               opos  <= rem_opos;
            end else begin
               dvo  <= 1'b0;
               opos <= next_opos;
            end
         end else if (dvi && (dtypei == DTYPE_FRAME_START || dtypei == DTYPE_HEADER_START)) begin
            opos     <= '0;
            hdr_slot <= '0;
            dvo      <= 1'b1;
            datao    <= '0;
         end else if (dvi && dtypei == DTYPE_HEADER) begin
            hdr_slot <= hdr_slot + SLOT_WIDTH'(1);
            if (hdr_slot[0]) begin // Odd slot completes the pair
               datao[31:16] <= meta_field;
               dvo          <= 1'b1;
            end else begin
               datao[15:0] <= meta_field;
               dvo         <= 1'b0;
            end
         end else begin
            dvo   <= dvi;
            datao <= '0;
         end
      end
   end

   // Every full word has to leave the buffer in the same cycle it fills
   a_fill_below_word: assert property (@(posedge clk) disable iff (!resetb)
      opos < POS_WIDTH'(32));

endmodule

`default_nettype wire

//--- verilog/stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module stream_top
   import stream_pkg::*;
   import cfg_pkg::*;
#(
   parameter int PIXEL_WIDTH = 8
) (
   input  wire          clk,
   input  wire          resetb,

   input  wire          psel,
   input  wire          penable,
   input  wire          pwrite,
   input  wire [7:0]    paddr,
   input  wire [31:0]   pwdata,
   output logic [31:0]  prdata,
   output logic         pready,
   output logic         pslverr,

   output logic         dvo,
   output dtype_e       dtypeo,
   output logic [31:0]  datao
);

   logic                   enable;
   logic                   start;
   image_type_e            image_type;
   logic [15:0]            num_cols;
   logic [15:0]            num_rows;
   logic                   busy;
   logic [15:0]            frame_count;

   // Beat from the sequencer into the packer
   logic                   dvi;
   dtype_e                 dtypei;
   logic [15:0]            meta_datai;
   logic [PIXEL_WIDTH-1:0] r;
   logic [PIXEL_WIDTH-1:0] g;
   logic [PIXEL_WIDTH-1:0] b;

   apb_cfg_regs u_regs (
      .clk         (clk),
      .resetb      (resetb),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .enable      (enable),
      .start       (start),
      .image_type  (image_type),
      .num_cols    (num_cols),
      .num_rows    (num_rows),
      .busy        (busy),
      .frame_count (frame_count)
   );

   frame_sequencer #(
      .PIXEL_WIDTH (PIXEL_WIDTH)
   ) u_seq (
      .clk         (clk),
      .resetb      (resetb),
      .enable      (enable),
      .start       (start),
      .image_type  (image_type),
      .num_cols    (num_cols),
      .num_rows    (num_rows),
      .busy        (busy),
      .frame_count (frame_count),
      .dvi         (dvi),
      .dtypei      (dtypei),
      .meta_datai  (meta_datai),
      .r           (r),
      .g           (g),
      .b           (b)
   );

   pixel_packer #(
      .PIXEL_WIDTH (PIXEL_WIDTH)
   ) u_pack (
      .clk         (clk),
      .resetb      (resetb),
      .image_type  (image_type), // Live register value, not the frame copy
      .dvi         (dvi),
      .dtypei      (dtypei),
      .meta_datai  (meta_datai),
      .r           (r),
      .g           (g),
      .b           (b),
      .dvo         (dvo),
      .dtypeo      (dtypeo),
      .datao       (datao)
   );

endmodule

`default_nettype wire

//--- tests/tb_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stream_top
   import stream_pkg::*;
   import cfg_pkg::*;
;

   localparam int PIXEL_WIDTH = 8;

   logic        clk;
   logic        resetb;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        dvo;
   dtype_e      dtypeo;
   logic [31:0] datao;

   integer      seed;
   int          errors;
   int          timeouts;
   logic [15:0] fc_model;
   string       test_name;
   logic [3:0]  exp_tag[$];
   logic [31:0] exp_data[$];
   logic [3:0]  e_tag;
   logic [31:0] e_data;

   stream_top #(
      .PIXEL_WIDTH (PIXEL_WIDTH)
   ) uut (
      .clk     (clk),
      .resetb  (resetb),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .dvo     (dvo),
      .dtypeo  (dtypeo),
      .datao   (datao)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Framing beats never carry data
   a_framing_zero: assert property (@(posedge clk) disable iff (!resetb)
      (dvo && (dtypeo == DTYPE_FRAME_START || dtypeo == DTYPE_HEADER_START ||
               dtypeo == DTYPE_LINE_START || dtypeo == DTYPE_LINE_END ||
               dtypeo == DTYPE_FRAME_END)) |-> datao == 32'd0)
      else begin
         errors++;
         $display("error framing_data: expected 00000000 actual %h", $sampled(datao));
      end

   a_valid_tag: assert property (@(posedge clk) disable iff (!resetb)
      dvo |-> dtypeo != DTYPE_NONE)
      else begin
         errors++;
         $display("valid output beat carries no tag");
      end

   // The slave answers every access in its first access cycle
   a_no_wait: assert property (@(posedge clk) disable iff (!resetb)
      (psel && penable) |-> pready)
      else begin
         errors++;
         $display("error %s: expected pready 1 actual %0b", test_name, $sampled(pready));
      end

   // Outputs are registered, so they are stable at the falling edge
   always @(negedge clk) begin
      if (resetb && dvo) begin
         if (exp_tag.size() == 0) begin
            errors++;
            $display("unexpected output beat with tag %0h in %s", dtypeo, test_name);
         end else begin
            e_tag  = exp_tag.pop_front();
            e_data = exp_data.pop_front();
            a_beat: assert (dtypeo == e_tag && datao == e_data) else begin
               errors++;
               $display("error %s: expected tag %0h data %h, actual tag %0h data %h",
                        test_name, e_tag, e_data, dtypeo, datao);
            end
         end
      end
   end

   task automatic push(input logic [3:0] tag, input logic [31:0] data);
      exp_tag.push_back(tag);
      exp_data.push_back(data);
   endtask

   // Pattern bits are concatenated oldest first and cut into 32-bit words
   task automatic push_pixels(input int cols, input int y, input bit rgb);
      logic [63:0]              acc;
      int                       nbits;
      logic [3*PIXEL_WIDTH-1:0] rgb_val;
      logic [PIXEL_WIDTH-1:0]   raw_val;
      acc   = '0;
      nbits = 0;
      for (int c = 0; c < cols; c++) begin
         rgb_val = {PIXEL_WIDTH'(c), PIXEL_WIDTH'(y), PIXEL_WIDTH'(c ^ y)};
         raw_val = PIXEL_WIDTH'(c + y);
         if (rgb) begin
            acc   = (acc << (3 * PIXEL_WIDTH)) | 64'(rgb_val);
            nbits += 3 * PIXEL_WIDTH;
         end else begin
            acc   = (acc << PIXEL_WIDTH) | 64'(raw_val);
            nbits += PIXEL_WIDTH;
         end
         if (nbits >= 32) begin
            push(DTYPE_PIXEL, 32'(acc >> (nbits - 32)));
            nbits -= 32;
            acc &= (64'd1 << nbits) - 64'd1;
         end
      end
   endtask

   task automatic build_frame(input int cols, input int rows, input image_type_e itype);
      push(DTYPE_FRAME_START, 32'd0);
      push(DTYPE_HEADER_START, 32'd0);
      push(DTYPE_HEADER, {16'(rows), 16'(cols)});
      push(DTYPE_HEADER, {fc_model, 16'(itype)});
      for (int y = 0; y < rows; y++) begin
         push(DTYPE_LINE_START, 32'd0);
         push_pixels(cols, y, itype == IMAGE_RGB);
         push(DTYPE_LINE_END, 32'd0);
      end
      push(DTYPE_FRAME_END, 32'd0);
   endtask

   // Both APB tasks start and end on a falling edge
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      err = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #1;
      data = prdata;
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_read(input string name, input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] data;
      logic        err;
      apb_read(addr, data, err);
      a_read: assert (data == exp && !err) else begin
         errors++;
         $display("error %s: expected %h actual %h (pslverr %0b)", name, exp, data, err);
      end
   endtask

   task automatic check_err(input string name, input logic err, input logic exp);
      a_err: assert (err == exp) else begin
         errors++;
         $display("error %s: expected pslverr %0b actual %0b", name, exp, err);
      end
   endtask

   task automatic wait_idle();
      logic [31:0] status;
      logic        err;
      int          polls;
      status = 32'd1;
      polls  = 0;
      while (status[0] && polls < 200) begin
         apb_read(ADDR_STATUS, status, err);
         polls++;
      end
      if (status[0]) begin
         timeouts++;
         $display("timeout waiting for busy to clear in %s", test_name);
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_tag.size() != 0 && cycles < 500) begin
         @(negedge clk);
         cycles++;
      end
      if (exp_tag.size() != 0) begin
         timeouts++;
         $display("timeout: %0d expected beats never came out in %s", exp_tag.size(), test_name);
         exp_tag.delete();
         exp_data.delete();
      end
   endtask

   task automatic run_frame(input string name, input int cols, input int rows,
                            input image_type_e itype, input bit double_start);
      logic err;
      test_name = name;
      apb_write(ADDR_IMAGE_TYPE, 32'(itype), err);
      apb_write(ADDR_NUM_COLS, cols, err);
      apb_write(ADDR_NUM_ROWS, rows, err);
      build_frame(cols, rows, itype);
      apb_write(ADDR_CTRL, 32'h3, err);
      if (double_start) begin
         apb_write(ADDR_CTRL, 32'h3, err); // Lands while the frame is running
      end
      wait_idle();
      wait_drain();
      fc_model = fc_model + 16'd1;
      check_read({name, "_status"}, ADDR_STATUS, {fc_model, 16'd0});
   endtask

   task automatic quiet_window(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
      end
   endtask

   initial begin
      logic        err;
      logic [31:0] rdata;
      int          cols;
      int          rows;
      image_type_e itype;
      seed      = 32'h5de6dfb0;
      errors    = 0;
      timeouts  = 0;
      fc_model  = 16'd0;
      test_name = "reset";
      resetb    = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = 8'h00;
      pwdata    = 32'd0;
      repeat (5) @(negedge clk);
      resetb = 1'b1;
      @(negedge clk);

      a_reset_dvo: assert (dvo == 1'b0 && datao == 32'd0) else begin
         errors++;
         $display("error reset: expected dvo 0 data 0 actual dvo %0b data %h", dvo, datao);
      end
      check_read("reset_status", ADDR_STATUS, 32'd0);

      test_name = "registers";
      apb_write(ADDR_CTRL, 32'h1, err);
      check_err("ctrl_write", err, 1'b0);
      apb_write(ADDR_IMAGE_TYPE, 32'h1, err);
      apb_write(ADDR_NUM_COLS, 32'h24, err);
      apb_write(ADDR_NUM_ROWS, 32'h13, err);
      check_read("ctrl_readback", ADDR_CTRL, 32'h1);
      check_read("type_readback", ADDR_IMAGE_TYPE, 32'h1);
      check_read("cols_readback", ADDR_NUM_COLS, 32'h24);
      check_read("rows_readback", ADDR_NUM_ROWS, 32'h13);
      apb_write(ADDR_STATUS, 32'hffff_ffff, err);
      check_err("status_write", err, 1'b1);
      apb_read(8'h14, rdata, err);
      check_err("unmapped_read", err, 1'b1);
      apb_write(8'h40, 32'h1, err);
      check_err("unmapped_write", err, 1'b1);

      run_frame("rgb_frame", 8, 3, IMAGE_RGB, 1'b0);
      run_frame("raw_frame", 12, 2, IMAGE_RAW, 1'b0);
      run_frame("busy_start", 4, 2, IMAGE_RGB, 1'b1);

      // A start with enable low must not produce a frame
      test_name = "disabled_start";
      apb_write(ADDR_CTRL, 32'h2, err);
      quiet_window(12);
      check_read("disabled_status", ADDR_STATUS, {fc_model, 16'd0});

      for (int i = 0; i < 4; i++) begin
         cols  = 4 * (1 + ($random(seed) & 3));
         rows  = 1 + ($random(seed) & 3);
         itype = image_type_e'(16'($random(seed) & 1));
         run_frame("random_frame", cols, rows, itype, 1'b0);
      end
      quiet_window(8);

      $display("errors: %0d wrong values, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
verilog/stream_pkg.sv
verilog/cfg_pkg.sv
verilog/apb_cfg_regs.sv
verilog/frame_sequencer.sv
verilog/pixel_packer.sv
verilog/stream_top.sv
tests/tb_stream_top.sv
